// File: hw/mul_config.svh
////////////////////////////////////////
// multiply unit configuration
// widths, pipeline depth and queue size
////////////////////////////////////////
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// operand and result width
`define MUL_DATA_WIDTH 64

// physical register tag width
`define MUL_TAG_WIDTH 7

// each multiplier stage adds a DATA_WIDTH/STAGES bit chunk
`define MUL_STAGES 4

// completion queue slots and initial credit count
`define MUL_QUEUE_DEPTH 4

`endif

// File: hw/mul_pkg.sv
////////////////////////////////////////
// multiply unit shared types
// data and tag words, instruction word views
////////////////////////////////////////
`include "mul_config.svh"

package mul_pkg;

  typedef logic [`MUL_DATA_WIDTH-1:0] mul_data_t;
  typedef logic [`MUL_TAG_WIDTH-1:0]  mul_tag_t;

  // register form of the operate format (rb supplies operand b)
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [2:0] sbz;       // should be zero
    logic       lit_flag;  // bit 12
    logic [6:0] func;
    logic [4:0] rc;
  } mul_rform_t;

  // literal form of the operate format (bits 20..13 hold the literal)
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [7:0] literal;
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } mul_lform_t;

  typedef union packed {
    mul_rform_t r;
    mul_lform_t l;
  } mul_inst_u;

endpackage

// File: hw/mul_issue.sv
////////////////////////////////////////
// multiply issue stage
// accepts one op per cycle against queue credits,
// picks operand b and registers the op
////////////////////////////////////////
`include "mul_config.svh"

module mul_issue (
  input  logic                clock,
  input  logic                reset,
  input  logic                rs_valid,
  input  mul_pkg::mul_inst_u  rs_inst,
  input  mul_pkg::mul_data_t  rs_opa,
  input  mul_pkg::mul_data_t  rs_opb,
  input  mul_pkg::mul_tag_t   rs_tag,
  input  logic                credit_return,
  output logic                mul_avail,
  output logic                issue_valid,
  output mul_pkg::mul_data_t  issue_opa,
  output mul_pkg::mul_data_t  issue_opb,
  output mul_pkg::mul_tag_t   issue_tag
);

  localparam int CREDIT_W = $clog2(`MUL_QUEUE_DEPTH + 1);
  localparam int LIT_W    = 8;

  logic [CREDIT_W-1:0] credit_count;
  logic                accept;
  mul_pkg::mul_data_t  opb_sel;

  assign mul_avail = (credit_count != '0);
  assign accept    = rs_valid & mul_avail;

  // literal form replaces rb with the zero-extended 8-bit literal
  always_comb
  begin
    if (rs_inst.r.lit_flag)
      opb_sel = {{(`MUL_DATA_WIDTH-LIT_W){1'b0}}, rs_inst.l.literal};
    else
      opb_sel = rs_opb;
  end

  ////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      credit_count <= CREDIT_W'(`MUL_QUEUE_DEPTH);
    else
    begin
      case ({accept, credit_return})
        2'b10:   credit_count <= credit_count - CREDIT_W'(1);  // slot taken
        2'b01:   credit_count <= credit_count + CREDIT_W'(1);  // slot freed
        default: credit_count <= credit_count;                 // none or both
      endcase
    end
  end

  ////////////////////////////////////////
  // issue register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      issue_valid <= 1'b0;
    else
      issue_valid <= accept;
  end

  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      issue_opa <= rs_opa;
      issue_opb <= opb_sel;
      issue_tag <= rs_tag;
    end
  end

endmodule

// File: hw/mul_stage.sv
////////////////////////////////////////
// multiplier stage
// adds one 16-bit partial product per cycle
////////////////////////////////////////
`include "mul_config.svh"

module mul_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                start,
  input  mul_pkg::mul_data_t  product_in,
  input  mul_pkg::mul_data_t  mplier_in,
  input  mul_pkg::mul_data_t  mcand_in,
  input  mul_pkg::mul_tag_t   tag_in,
  output logic                done,
  output mul_pkg::mul_data_t  product_out,
  output mul_pkg::mul_data_t  mplier_out,
  output mul_pkg::mul_data_t  mcand_out,
  output mul_pkg::mul_tag_t   tag_out
);

  localparam int CHUNK = `MUL_DATA_WIDTH / `MUL_STAGES;

  mul_pkg::mul_data_t prod_in_reg;
  mul_pkg::mul_data_t partial_reg;
  mul_pkg::mul_data_t partial_product;

  // low chunk of the multiplier times the whole multiplicand in 64 bits
  assign partial_product = mul_pkg::mul_data_t'(mplier_in[CHUNK-1:0] * mcand_in);

  assign product_out = prod_in_reg + partial_reg;

  always_ff @(posedge clock)
  begin
    prod_in_reg <= product_in;
    partial_reg <= partial_product;
    mplier_out  <= mplier_in >> CHUNK;  // next chunk moves down
    mcand_out   <= mcand_in << CHUNK;   // weight follows it up
    tag_out     <= tag_in;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      done <= 1'b0;
    else
      done <= start;
  end

endmodule

// File: hw/mul_pipe.sv
////////////////////////////////////////
// pipelined multiplier
// MUL_STAGES chained stages, fixed latency,
// valid and tag ride along with the data
////////////////////////////////////////
`include "mul_config.svh"

module mul_pipe (
  input  logic                clock,
  input  logic                reset,
  input  logic                issue_valid,
  input  mul_pkg::mul_data_t  issue_opa,
  input  mul_pkg::mul_data_t  issue_opb,
  input  mul_pkg::mul_tag_t   issue_tag,
  output logic                pipe_valid,
  output mul_pkg::mul_data_t  pipe_result,
  output mul_pkg::mul_tag_t   pipe_tag
);

  // index i is the input of stage i, index MUL_STAGES the pipe output
  logic               valid_chain   [`MUL_STAGES+1];
  mul_pkg::mul_data_t product_chain [`MUL_STAGES+1];
  mul_pkg::mul_data_t mplier_chain  [`MUL_STAGES+1];
  mul_pkg::mul_data_t mcand_chain   [`MUL_STAGES+1];
  mul_pkg::mul_tag_t  tag_chain     [`MUL_STAGES+1];

  assign valid_chain[0]   = issue_valid;
  assign product_chain[0] = '0;          // nothing accumulated yet
  assign mplier_chain[0]  = issue_opa;
  assign mcand_chain[0]   = issue_opb;
  assign tag_chain[0]     = issue_tag;

  for (genvar i = 0; i < `MUL_STAGES; i++)
  begin : g_stage
    mul_stage u_stage (
      .clock       (clock),
      .reset       (reset),
      .start       (valid_chain[i]),
      .product_in  (product_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .tag_in      (tag_chain[i]),
      .done        (valid_chain[i+1]),
      .product_out (product_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1]),
      .tag_out     (tag_chain[i+1])
    );
  end

  assign pipe_valid  = valid_chain[`MUL_STAGES];
  assign pipe_result = product_chain[`MUL_STAGES];
  assign pipe_tag    = tag_chain[`MUL_STAGES];

endmodule

// File: hw/mul_complete_queue.sv
////////////////////////////////////////
// completion queue
// circular FIFO of finished results,
// one credit pulse back to issue per pop
////////////////////////////////////////
`include "mul_config.svh"

module mul_complete_queue (
  input  logic                clock,
  input  logic                reset,
  input  logic                pipe_valid,
  input  mul_pkg::mul_data_t  pipe_result,
  input  mul_pkg::mul_tag_t   pipe_tag,
  input  logic                queue_pop,
  output logic                queue_valid,
  output mul_pkg::mul_data_t  queue_result,
  output mul_pkg::mul_tag_t   queue_tag,
  output logic                credit_return
);

  localparam int PTR_W = $clog2(`MUL_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`MUL_QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`MUL_QUEUE_DEPTH - 1);

  mul_pkg::mul_data_t result_mem [`MUL_QUEUE_DEPTH];
  mul_pkg::mul_tag_t  tag_mem    [`MUL_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // head is read straight out of the array
  assign queue_valid  = (count != '0);
  assign queue_result = result_mem[rd_ptr];
  assign queue_tag    = tag_mem[rd_ptr];

  ////////////////////////////////////////
  // storage written on every valid result
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (pipe_valid)
    begin
      result_mem[wr_ptr] <= pipe_result;
      tag_mem[wr_ptr]    <= pipe_tag;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (pipe_valid)
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + PTR_W'(1);
      if (queue_pop)
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + PTR_W'(1);

      case ({pipe_valid, queue_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // push and pop cancel
      endcase

      credit_return <= queue_pop;  // slot handed back next cycle
    end
  end

endmodule

// File: hw/mul_cdb_driver.sv
////////////////////////////////////////
// CDB driver
// holds one result on the bus until granted
////////////////////////////////////////

module mul_cdb_driver (
  input  logic                clock,
  input  logic                reset,
  input  logic                queue_valid,
  input  mul_pkg::mul_data_t  queue_result,
  input  mul_pkg::mul_tag_t   queue_tag,
  input  logic                cdb_grant,
  output logic                queue_pop,
  output logic                cdb_valid,
  output mul_pkg::mul_data_t  cdb_result,
  output mul_pkg::mul_tag_t   cdb_tag
);

  logic slot_free;

  // register empties this cycle if it is idle or its broadcast is granted
  assign slot_free = ~cdb_valid | cdb_grant;
  assign queue_pop = queue_valid & slot_free;

  ////////////////////////////////////////
  // broadcast register
  ////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      cdb_valid <= 1'b0;
    else if (queue_pop)
      cdb_valid <= 1'b1;        // next entry follows back to back under grant
    else if (cdb_grant)
      cdb_valid <= 1'b0;        // granted and nothing waiting
  end

  // payload only moves on a pop, so it holds while the grant is low
  always_ff @(posedge clock)
  begin
    if (queue_pop)
    begin
      cdb_result <= queue_result;
      cdb_tag    <= queue_tag;
    end
  end

endmodule

// File: hw/mul_unit.sv
////////////////////////////////////////
// integer multiply functional unit
// issue, pipelined multiplier, completion
// queue and CDB driver
////////////////////////////////////////

module mul_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                rs_valid,
  input  mul_pkg::mul_inst_u  rs_inst,
  input  mul_pkg::mul_data_t  rs_opa,
  input  mul_pkg::mul_data_t  rs_opb,
  input  mul_pkg::mul_tag_t   rs_tag,
  input  logic                cdb_grant,
  output logic                mul_avail,
  output logic                cdb_valid,
  output mul_pkg::mul_data_t  cdb_result,
  output mul_pkg::mul_tag_t   cdb_tag
);

  logic               issue_valid;
  mul_pkg::mul_data_t issue_opa;
  mul_pkg::mul_data_t issue_opb;
  mul_pkg::mul_tag_t  issue_tag;

  logic               pipe_valid;
  mul_pkg::mul_data_t pipe_result;
  mul_pkg::mul_tag_t  pipe_tag;

  logic               queue_valid;
  mul_pkg::mul_data_t queue_result;
  mul_pkg::mul_tag_t  queue_tag;
  logic               queue_pop;
  logic               credit_return;

  ////////////////////////////////////////
  // issue and execute
  ////////////////////////////////////////
  mul_issue u_issue (
    .clock         (clock),
    .reset         (reset),
    .rs_valid      (rs_valid),
    .rs_inst       (rs_inst),
    .rs_opa        (rs_opa),
    .rs_opb        (rs_opb),
    .rs_tag        (rs_tag),
    .credit_return (credit_return),
    .mul_avail     (mul_avail),
    .issue_valid   (issue_valid),
    .issue_opa     (issue_opa),
    .issue_opb     (issue_opb),
    .issue_tag     (issue_tag)
  );

  mul_pipe u_pipe (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_opa   (issue_opa),
    .issue_opb   (issue_opb),
    .issue_tag   (issue_tag),
    .pipe_valid  (pipe_valid),
    .pipe_result (pipe_result),
    .pipe_tag    (pipe_tag)
  );

  ////////////////////////////////////////
  // completion and broadcast
  ////////////////////////////////////////
  mul_complete_queue u_queue (
    .clock         (clock),
    .reset         (reset),
    .pipe_valid    (pipe_valid),
    .pipe_result   (pipe_result),
    .pipe_tag      (pipe_tag),
    .queue_pop     (queue_pop),
    .queue_valid   (queue_valid),
    .queue_result  (queue_result),
    .queue_tag     (queue_tag),
    .credit_return (credit_return)
  );

  mul_cdb_driver u_driver (
    .clock        (clock),
    .reset        (reset),
    .queue_valid  (queue_valid),
    .queue_result (queue_result),
    .queue_tag    (queue_tag),
    .cdb_grant    (cdb_grant),
    .queue_pop    (queue_pop),
    .cdb_valid    (cdb_valid),
    .cdb_result   (cdb_result),
    .cdb_tag      (cdb_tag)
  );

endmodule

// File: verif/mul_unit_tb.sv
////////////////////////////////////////
// multiply unit testbench
// random and directed multiplies checked
// against a reference model at the CDB
////////////////////////////////////////
`include "mul_config.svh"

module mul_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 100;
  localparam int HOLD_CYCLES = 24;   // presentation cycles while grant is low
  localparam int RAND_OPS    = 200;
  localparam int N_OPS       = 16 + 20 + 16 + HOLD_CYCLES + RAND_OPS;
  localparam int MAX_STALL   = 8;
  localparam int MARGIN      = 8;
  localparam int TIMEOUT_NS  = N_OPS * (`MUL_STAGES + MAX_STALL + MARGIN) * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic               clock;
  logic               reset;
  logic               rs_valid;
  mul_pkg::mul_inst_u rs_inst;
  mul_pkg::mul_data_t rs_opa;
  mul_pkg::mul_data_t rs_opb;
  mul_pkg::mul_tag_t  rs_tag;
  logic               cdb_grant;
  logic               mul_avail;
  logic               cdb_valid;
  mul_pkg::mul_data_t cdb_result;
  mul_pkg::mul_tag_t  cdb_tag;

  mul_pkg::mul_data_t exp_result_q [$];
  mul_pkg::mul_tag_t  exp_tag_q    [$];
  logic [31:0] stim_state  = 32'd28;
  logic [31:0] grant_state = 32'd28;
  int grant_mode = 1;  // 0 low, 1 high, 2 random
  int accept_count = 0;
  int result_errors = 0;
  int tag_errors = 0;
  int protocol_errors = 0;
  int flow_errors = 0;
  logic               hold_valid = 1'b0;
  mul_pkg::mul_data_t hold_result;
  mul_pkg::mul_tag_t  hold_tag;

  mul_unit dut (
    .clock      (clock),
    .reset      (reset),
    .rs_valid   (rs_valid),
    .rs_inst    (rs_inst),
    .rs_opa     (rs_opa),
    .rs_opb     (rs_opb),
    .rs_tag     (rs_tag),
    .cdb_grant  (cdb_grant),
    .mul_avail  (mul_avail),
    .cdb_valid  (cdb_valid),
    .cdb_result (cdb_result),
    .cdb_tag    (cdb_tag)
  );

  ////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_stim(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      stim_state = lfsr_step(stim_state);
      v = {v[62:0], stim_state[0]};  // one step per bit
    end
    return v;
  endfunction

  function automatic logic [63:0] rand_grant(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      grant_state = lfsr_step(grant_state);
      v = {v[62:0], grant_state[0]};
    end
    return v;
  endfunction

  // low 64 bits of opa times operand b, the literal sits in word bits 20..13
  function automatic mul_pkg::mul_data_t ref_mul(input mul_pkg::mul_inst_u inst,
                                                 input mul_pkg::mul_data_t a,
                                                 input mul_pkg::mul_data_t b);
    logic [31:0]        word;
    mul_pkg::mul_data_t opb;
    word = inst;
    if (word[12])
      opb = mul_pkg::mul_data_t'(word[20:13]);  // zero-extended literal
    else
      opb = b;
    return a * opb;
  endfunction

  function automatic mul_pkg::mul_inst_u make_inst(input logic lit);
    logic [31:0] word;
    word = 32'(rand_stim(32));
    word[12] = lit;  // literal flag
    return mul_pkg::mul_inst_u'(word);
  endfunction

  function automatic mul_pkg::mul_data_t pick_operand(input int kind);
    case (kind)
      0:       return '0;
      1:       return mul_pkg::mul_data_t'(1);
      2:       return '1;
      default: return mul_pkg::mul_data_t'(rand_stim(`MUL_DATA_WIDTH));
    endcase
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic check_result(input mul_pkg::mul_data_t got, input mul_pkg::mul_data_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t: cdb_result %h, expected %h", $time, got, exp);
      result_errors++;
    end
  endtask

  task automatic check_tag(input mul_pkg::mul_tag_t got, input mul_pkg::mul_tag_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t: cdb_tag %h, expected %h", $time, got, exp);
      tag_errors++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic drive_op(input mul_pkg::mul_inst_u inst, input mul_pkg::mul_data_t a,
                          input mul_pkg::mul_data_t b);
    @(posedge clock);
    rs_valid <= 1'b1;
    rs_inst  <= inst;
    rs_opa   <= a;
    rs_opb   <= b;  // ignored for literal form
    rs_tag   <= mul_pkg::mul_tag_t'(rand_stim(`MUL_TAG_WIDTH));
    @(negedge clock);
    while (!mul_avail)
      @(negedge clock);  // accepted on the next rising edge
  endtask

  task automatic go_idle();
    @(posedge clock);
    rs_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clock);
    while ((exp_result_q.size() != 0 || cdb_valid) && n < 400)
    begin
      @(negedge clock);
      n++;
    end
  endtask

  initial
  begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial
  begin
    cdb_grant = 1'b1;
    forever
    begin
      @(posedge clock);
      if (grant_mode == 2)
        cdb_grant <= (rand_grant(2) != '0);  // low one cycle in four
      else
        cdb_grant <= (grant_mode == 1);
    end
  end

  // an op is taken on the next rising edge when both are high here
  always @(negedge clock)
  begin
    if (!reset && rs_valid && mul_avail)
    begin
      exp_result_q.push_back(ref_mul(rs_inst, rs_opa, rs_opb));
      exp_tag_q.push_back(rs_tag);
      accept_count++;
    end
  end

  always @(negedge clock)
  begin
    if (!reset)
    begin
      if (hold_valid && (!cdb_valid || cdb_result !== hold_result || cdb_tag !== hold_tag))
      begin
        $display("ERR %0t: CDB output changed while waiting for grant", $time);
        protocol_errors++;
      end
      if (cdb_valid && cdb_grant)
      begin
        if (exp_result_q.size() == 0)
        begin
          $display("unexpected broadcast at %0t with no operation outstanding", $time);
          protocol_errors++;
        end
        else
        begin
          check_result(cdb_result, exp_result_q.pop_front());
          check_tag(cdb_tag, exp_tag_q.pop_front());
        end
      end
      hold_valid  = cdb_valid && !cdb_grant;
      hold_result = cdb_result;
      hold_tag    = cdb_tag;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    int base;
    reset    = 1'b1;
    rs_valid = 1'b0;
    rs_inst  = '0;
    rs_opa   = '0;
    rs_opb   = '0;
    rs_tag   = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    if (cdb_valid !== 1'b0 || mul_avail !== 1'b1)
    begin
      $display("ERR %0t: after reset cdb_valid %b mul_avail %b", $time, cdb_valid, mul_avail);
      flow_errors++;
    end

    // register form with corner operands then random ones
    for (int ka = 0; ka < 4; ka++)
      for (int kb = 0; kb < 4; kb++)
        drive_op(make_inst(1'b0), pick_operand(ka), pick_operand(kb));
    for (int i = 0; i < 20; i++)
      drive_op(make_inst(1'b0), pick_operand(3), pick_operand(3));

    // literal form with a random rs_opb that must not matter
    for (int i = 0; i < 16; i++)
      drive_op(make_inst(1'b1), pick_operand(3), pick_operand(3));
    go_idle();
    wait_drain();

    // back-pressure fills the queue slots and the driver register
    grant_mode = 0;
    base = accept_count;
    for (int i = 0; i < HOLD_CYCLES; i++)
    begin
      @(posedge clock);
      rs_valid <= 1'b1;
      rs_inst  <= make_inst(1'b0);
      rs_opa   <= pick_operand(3);
      rs_opb   <= pick_operand(3);
      rs_tag   <= mul_pkg::mul_tag_t'(rand_stim(`MUL_TAG_WIDTH));
    end
    go_idle();
    @(negedge clock);
    if (accept_count - base != `MUL_QUEUE_DEPTH + 1 || mul_avail)
    begin
      $display("ERR %0t: back-pressure accepted %0d operations, mul_avail %b",
               $time, accept_count - base, mul_avail);
      flow_errors++;
    end
    grant_mode = 1;
    wait_drain();

    // random grants and issue gaps
    @(negedge clock);
    grant_mode = 2;
    for (int i = 0; i < RAND_OPS; i++)
    begin
      if (rand_stim(2) == '0)
        go_idle();
      drive_op(make_inst(rand_stim(1) != '0), pick_operand(3), pick_operand(3));
    end
    go_idle();
    @(negedge clock);
    grant_mode = 1;
    wait_drain();
    if (exp_result_q.size() != 0)
    begin
      $display("%0d expected results never appeared on the CDB", exp_result_q.size());
      flow_errors++;
    end

    $display("errors: result %0d, tag %0d, protocol %0d, flow %0d",
             result_errors, tag_errors, protocol_errors, flow_errors);
    if (result_errors + tag_errors + protocol_errors + flow_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/mul_pkg.sv
hw/mul_issue.sv
hw/mul_stage.sv
hw/mul_pipe.sv
hw/mul_complete_queue.sv
hw/mul_cdb_driver.sv
hw/mul_unit.sv
verif/mul_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mul_unit_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass message appears as its own line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
